// ==== Makefile ====
# Verilator flow for the streaming Gaussian blur.

SIM       ?= verilator
TOP       ?= gauss_blur_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0
VFLAGS    ?= --timing --timescale $(TIMESCALE)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(SIM) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/gauss_blur_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gauss_blur_tb
	import blur_pkg::*;
();

	localparam int LINE_WIDTH = 16;
	localparam int FRAME_LINES = 10;
	localparam int FRAME_PIXELS = LINE_WIDTH * FRAME_LINES;
	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 12;
	localparam int LATENCY = 2;
	localparam int DRAIN_LIMIT = 10;
	localparam int MAX_GAP = 3;
	localparam int GAPS_NONE = 0;
	localparam int GAPS_ONE = 1;
	localparam int GAPS_RANDOM = 2;
	// Five dense frames, one with single gaps, one with gaps up to MAX_GAP.
	localparam int STROBE_CYCLES = FRAME_PIXELS * (5 + 2 + MAX_GAP + 1) + IDLE_CYCLES;
	localparam int CYCLE_LIMIT = 4 * STROBE_CYCLES;

	logic clk;
	logic reset;
	logic pixel_valid;
	logic [PIXEL_W-1:0] pixel_in;
	logic [PIXEL_W-1:0] side_in;
	logic [1:0] filt_sel;
	logic out_valid;
	logic [CHAN_W-1:0] out_r;
	logic [CHAN_W-1:0] out_g;
	logic [CHAN_W-1:0] out_b;
	logic [PIXEL_W-1:0] side_out;

	int seed;
	int cycle = 0;
	int error_count = 0;
	int check_count = 0;
	int missing_count = 0;
	int test_num = 0;
	int errors_at_start;
	int checks_at_start;
	int missing_at_start;
	string current_test;

	logic [PIXEL_W-1:0] frame [FRAME_LINES][LINE_WIDTH];
	logic [CHAN_W-1:0] exp_r_q [$];
	logic [CHAN_W-1:0] exp_g_q [$];
	logic [CHAN_W-1:0] exp_b_q [$];
	logic [PIXEL_W-1:0] side_q [$];
	bit check_q [$];
	int tag_q [$];
	int due_q [$];

	int gauss5_tab [5][5] = '{
		'{9, 10, 10, 10, 9},
		'{10, 11, 11, 11, 10},
		'{10, 11, 11, 11, 10},
		'{10, 11, 11, 9, 10},
		'{9, 10, 10, 10, 11}
	};

	int gauss7_tab [7][7] = '{
		'{3, 4, 5, 5, 5, 4, 3},
		'{4, 5, 6, 6, 6, 5, 4},
		'{5, 6, 7, 7, 7, 6, 5},
		'{5, 6, 7, 8, 7, 6, 5},
		'{5, 6, 7, 7, 7, 6, 5},
		'{4, 5, 6, 6, 6, 5, 4},
		'{3, 4, 5, 5, 5, 4, 3}
	};

	gauss_blur #(
		.LINE_WIDTH(LINE_WIDTH)
	) gauss_blur_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.side_in(side_in),
		.filt_sel(filt_sel),
		.out_valid(out_valid),
		.out_r(out_r),
		.out_g(out_g),
		.out_b(out_b),
		.side_out(side_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	// ====================
	// Reference model
	// ====================
	function automatic int channel_of(input logic [PIXEL_W-1:0] px, input int ch);
		logic [PIXEL_W-1:0] shifted;
		shifted = px >> ((2 - ch) * CHAN_W); // Channel 0 is red.
		return int'(shifted[CHAN_W-1:0]);
	endfunction

	function automatic int kernel_weight(input logic [1:0] mode, input int r, input int c);
		int w;
		w = 0;
		case (mode)
			FILT_GAUSS5: begin
				if (r >= 1 && r <= 5 && c >= 1 && c <= 5)
					w = gauss5_tab[r-1][c-1];
			end
			FILT_GAUSS7: w = gauss7_tab[r][c];
			default: begin
				if (r == KERNEL_CENTER && c == KERNEL_CENTER)
					w = 255; // Identity and spare.
			end
		endcase
		return w;
	endfunction

	// Window's bottom-right is the pixel at (line, col).
	function automatic logic [CHAN_W-1:0] expected_channel(input logic [1:0] mode,
			input int line, input int col, input int ch);
		int sum;
		sum = 0;
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				sum += kernel_weight(mode, r, c) *
					channel_of(frame[line-KERNEL_SIZE+1+r][col-KERNEL_SIZE+1+c], ch);
			end
		end
		sum = sum >> COEFF_SHIFT;
		if (sum > 255)
			sum = 255;
		return CHAN_W'(sum);
	endfunction

	// ====================
	// Compare
	// ====================
	task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic note_failure(input string msg);
		error_count++;
		$display("Failure at %0t ns: %s", $time, msg);
	endtask

	always @(negedge clk) begin
		int due;
		int tag;
		logic [CHAN_W-1:0] er;
		logic [CHAN_W-1:0] eg;
		logic [CHAN_W-1:0] eb;
		logic [PIXEL_W-1:0] es;
		bit chk;
		string where;
		if (!reset) begin
			if (pixel_valid)
				due_q.push_back(cycle + LATENCY + 1); // Seen a cycle before its edge.
			if (out_valid) begin
				if (exp_r_q.size() == 0 || due_q.size() == 0) begin
					note_failure("out_valid pulsed with no pixel in flight");
				end else begin
					due = due_q.pop_front();
					er = exp_r_q.pop_front();
					eg = exp_g_q.pop_front();
					eb = exp_b_q.pop_front();
					es = side_q.pop_front();
					chk = check_q.pop_front();
					tag = tag_q.pop_front();
					where = $sformatf("pixel %0d,%0d", tag / LINE_WIDTH, tag % LINE_WIDTH);
					if (due != cycle)
						note_failure($sformatf("out_valid for %s came at cycle %0d, not %0d",
							where, cycle, due));
					if (chk) begin
						check_value(32'(out_r), 32'(er), {"red of ", where});
						check_value(32'(out_g), 32'(eg), {"green of ", where});
						check_value(32'(out_b), 32'(eb), {"blue of ", where});
						check_value(32'(side_out), 32'(es), {"sideband of ", where});
					end
				end
			end
		end
	end

	// ====================
	// Stimulus
	// ====================
	task automatic fill_frame(input bit all_max);
		for (int l = 0; l < FRAME_LINES; l++) begin
			for (int c = 0; c < LINE_WIDTH; c++) begin
				frame[l][c] = all_max ? '1 : PIXEL_W'($random(seed));
			end
		end
	endtask

	task automatic set_mode(input logic [1:0] mode);
		@(posedge clk);
		filt_sel <= mode;
	endtask

	task automatic drive_frame(input logic [1:0] mode, input int gap_kind);
		int gap;
		bit check;
		logic [PIXEL_W-1:0] side_word;
		for (int l = 0; l < FRAME_LINES; l++) begin
			for (int c = 0; c < LINE_WIDTH; c++) begin
				side_word = PIXEL_W'($random(seed));
				check = (l >= KERNEL_SIZE - 1) && (c >= KERNEL_SIZE - 1);
				if (check) begin
					exp_r_q.push_back(expected_channel(mode, l, c, 0));
					exp_g_q.push_back(expected_channel(mode, l, c, 1));
					exp_b_q.push_back(expected_channel(mode, l, c, 2));
				end else begin
					exp_r_q.push_back(CHAN_W'(0)); // Edge pixel, not checked.
					exp_g_q.push_back(CHAN_W'(0));
					exp_b_q.push_back(CHAN_W'(0));
				end
				side_q.push_back(side_word);
				check_q.push_back(check);
				tag_q.push_back(l * LINE_WIDTH + c);
				@(posedge clk);
				pixel_valid <= 1'b1;
				pixel_in <= frame[l][c];
				side_in <= side_word;
				if (gap_kind == GAPS_NONE)
					gap = 0;
				else if (gap_kind == GAPS_ONE)
					gap = 1;
				else
					gap = $random(seed) & MAX_GAP;
				repeat (gap) begin
					@(posedge clk);
					pixel_valid <= 1'b0;
					pixel_in <= PIXEL_W'($random(seed)); // Junk while idle.
					side_in <= PIXEL_W'($random(seed));
				end
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic begin_test(input string name);
		test_num++;
		current_test = name;
		errors_at_start = error_count;
		checks_at_start = check_count;
		missing_at_start = missing_count;
	endtask

	task automatic end_test();
		int waited;
		int failures;
		waited = 0;
		while (exp_r_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_r_q.size() != 0) begin
			$display("Failure at %0t ns: %0d pixels never produced out_valid",
				$time, exp_r_q.size());
			missing_count += exp_r_q.size();
			exp_r_q.delete();
			exp_g_q.delete();
			exp_b_q.delete();
			side_q.delete();
			check_q.delete();
			tag_q.delete();
			due_q.delete();
		end
		failures = (error_count - errors_at_start) + (missing_count - missing_at_start);
		$display("Test %0d %s finished: %0d checks, %0d failures", test_num, current_test,
			check_count - checks_at_start, failures);
	endtask

	initial begin
		$timeformat(-9, 0, "", 0);
		seed = 32'hc8e8;
		reset <= 1'b1;
		pixel_valid <= 1'b0;
		pixel_in <= '0;
		side_in <= '0;
		filt_sel <= FILT_IDENTITY;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		begin_test("reset_and_latency");
		repeat (IDLE_CYCLES) @(posedge clk); // Any out_valid here is extra.
		fill_frame(1'b0);
		set_mode(FILT_IDENTITY);
		drive_frame(FILT_IDENTITY, GAPS_ONE);
		end_test();

		begin_test("identity");
		fill_frame(1'b0);
		drive_frame(FILT_IDENTITY, GAPS_NONE);
		end_test();

		begin_test("gauss5_dense");
		fill_frame(1'b0);
		set_mode(FILT_GAUSS5);
		drive_frame(FILT_GAUSS5, GAPS_NONE);
		end_test();

		begin_test("gauss7_saturation");
		fill_frame(1'b1);
		set_mode(FILT_GAUSS7);
		drive_frame(FILT_GAUSS7, GAPS_NONE);
		end_test();

		begin_test("gauss7_random");
		fill_frame(1'b0);
		drive_frame(FILT_GAUSS7, GAPS_NONE);
		end_test();

		begin_test("gauss7_gaps");
		fill_frame(1'b0);
		drive_frame(FILT_GAUSS7, GAPS_RANDOM);
		end_test();

		begin_test("spare_code");
		fill_frame(1'b0);
		set_mode(FILT_SPARE);
		drive_frame(FILT_SPARE, GAPS_NONE);
		end_test();

		$display("Summary: %0d tests, %0d checks, %0d failures", test_num, check_count,
			error_count + missing_count);
		if (error_count + missing_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/blur_pkg.sv
verilog/kernel_coeff_decode.sv
verilog/line_window.sv
verilog/convolve_mac.sv
verilog/pixel_result.sv
verilog/gauss_blur.sv
verification/gauss_blur_tb.sv

// ==== verilog/blur_pkg.sv ====
`default_nettype none

package blur_pkg;

	// ====================
	// Pixel and weight widths
	// ====================
	localparam int CHAN_W = 8;
	localparam int PIXEL_W = 3 * CHAN_W; // Red high, green middle, blue low.
	localparam int COEFF_W = 8;
	localparam int COEFF_SHIFT = 8; // Weights in units of 1/256.

	// ====================
	// Window geometry
	// ====================
	localparam int KERNEL_SIZE = 7;
	localparam int KERNEL_CENTER = 3;

	// 49 terms need 6 bits of growth.
	localparam int SUM_W = CHAN_W + COEFF_W + 6;

	// ====================
	// Filter mode codes
	// ====================
	localparam logic [1:0] FILT_IDENTITY = 2'd0;
	localparam logic [1:0] FILT_GAUSS5 = 2'd1;
	localparam logic [1:0] FILT_GAUSS7 = 2'd2;
	localparam logic [1:0] FILT_SPARE = 2'd3; // Falls back to identity.

endpackage

`default_nettype wire

// ==== verilog/convolve_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module convolve_mac
	import blur_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [PIXEL_W-1:0] window [KERNEL_SIZE][KERNEL_SIZE],
	input wire logic window_valid,
	input wire logic [COEFF_W-1:0] coeff [KERNEL_SIZE][KERNEL_SIZE],
	output logic [SUM_W-1:0] sum_r,
	output logic [SUM_W-1:0] sum_g,
	output logic [SUM_W-1:0] sum_b,
	output logic sum_valid
);

	localparam int NUM_CHAN = PIXEL_W / CHAN_W;

	logic [SUM_W-1:0] acc [NUM_CHAN];

	// Channel 0 is red, taken from the top byte.
	always_comb begin
		logic [CHAN_W+COEFF_W-1:0] prod;
		prod = '0;
		for (int ch = 0; ch < NUM_CHAN; ch++) begin
			acc[ch] = '0;
			for (int r = 0; r < KERNEL_SIZE; r++) begin
				for (int c = 0; c < KERNEL_SIZE; c++) begin
					prod = window[r][c][PIXEL_W-1-ch*CHAN_W -: CHAN_W] * coeff[r][c];
					acc[ch] = acc[ch] + SUM_W'(prod);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (window_valid) begin
			sum_r <= acc[0];
			sum_g <= acc[1];
			sum_b <= acc[2];
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			sum_valid <= 1'b0;
		else
			sum_valid <= window_valid;
	end

endmodule

`default_nettype wire

// ==== verilog/gauss_blur.sv ====
`timescale 1ns/1ps
`default_nettype none

module gauss_blur
	import blur_pkg::*;
#(
	parameter int LINE_WIDTH = 640
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	input wire logic [PIXEL_W-1:0] pixel_in,
	input wire logic [PIXEL_W-1:0] side_in,
	input wire logic [1:0] filt_sel,
	output logic out_valid,
	output logic [CHAN_W-1:0] out_r,
	output logic [CHAN_W-1:0] out_g,
	output logic [CHAN_W-1:0] out_b,
	output logic [PIXEL_W-1:0] side_out
);

	logic [PIXEL_W-1:0] window [KERNEL_SIZE][KERNEL_SIZE];
	logic window_valid;
	logic [COEFF_W-1:0] coeff [KERNEL_SIZE][KERNEL_SIZE];
	logic [SUM_W-1:0] sum_r;
	logic [SUM_W-1:0] sum_g;
	logic [SUM_W-1:0] sum_b;
	logic sum_valid;

	// ====================
	// Decode
	// ====================
	kernel_coeff_decode coeff_i (
		.filt_sel(filt_sel),
		.coeff(coeff)
	);

	// ====================
	// Window and MAC
	// ====================
	line_window #(
		.LINE_WIDTH(LINE_WIDTH)
	) window_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.window(window),
		.window_valid(window_valid)
	);

	convolve_mac mac_i (
		.clk(clk),
		.reset(reset),
		.window(window),
		.window_valid(window_valid),
		.coeff(coeff),
		.sum_r(sum_r),
		.sum_g(sum_g),
		.sum_b(sum_b),
		.sum_valid(sum_valid)
	);

	// ====================
	// Rescale and saturate
	// ====================
	pixel_result result_i (
		.clk(clk),
		.reset(reset),
		.sum_r(sum_r),
		.sum_g(sum_g),
		.sum_b(sum_b),
		.sum_valid(sum_valid),
		.side_in(side_in),
		.out_r(out_r),
		.out_g(out_g),
		.out_b(out_b),
		.out_valid(out_valid),
		.side_out(side_out)
	);

endmodule

`default_nettype wire

// ==== verilog/kernel_coeff_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_coeff_decode
	import blur_pkg::*;
(
	input wire logic [1:0] filt_sel,
	output logic [COEFF_W-1:0] coeff [KERNEL_SIZE][KERNEL_SIZE]
);

	// Row 0 is the oldest line, column 0 the oldest pixel of a row.
	always_comb begin
		for (int r = 0; r < KERNEL_SIZE; r++) begin
			for (int c = 0; c < KERNEL_SIZE; c++) begin
				coeff[r][c] = '0;
			end
		end

		case (filt_sel)
			FILT_IDENTITY, FILT_SPARE: begin
				coeff[KERNEL_CENTER][KERNEL_CENTER] = 8'd255; // Pass-through, slightly dimmed.
			end

			// ====================
			// 5x5, not symmetric
			// ====================
			FILT_GAUSS5: begin
				coeff[1] = '{8'd0, 8'd9, 8'd10, 8'd10, 8'd10, 8'd9, 8'd0};
				coeff[2] = '{8'd0, 8'd10, 8'd11, 8'd11, 8'd11, 8'd10, 8'd0};
				coeff[3] = '{8'd0, 8'd10, 8'd11, 8'd11, 8'd11, 8'd10, 8'd0};
				coeff[4] = '{8'd0, 8'd10, 8'd11, 8'd11, 8'd9, 8'd10, 8'd0};
				coeff[5] = '{8'd0, 8'd9, 8'd10, 8'd10, 8'd10, 8'd11, 8'd0};
			end

			// ====================
			// 7x7, weights sum to 260
			// ====================
			FILT_GAUSS7: begin
				coeff[0] = '{8'd3, 8'd4, 8'd5, 8'd5, 8'd5, 8'd4, 8'd3};
				coeff[1] = '{8'd4, 8'd5, 8'd6, 8'd6, 8'd6, 8'd5, 8'd4};
				coeff[2] = '{8'd5, 8'd6, 8'd7, 8'd7, 8'd7, 8'd6, 8'd5};
				coeff[3] = '{8'd5, 8'd6, 8'd7, 8'd8, 8'd7, 8'd6, 8'd5};
				coeff[4] = '{8'd5, 8'd6, 8'd7, 8'd7, 8'd7, 8'd6, 8'd5};
				coeff[5] = '{8'd4, 8'd5, 8'd6, 8'd6, 8'd6, 8'd5, 8'd4};
				coeff[6] = '{8'd3, 8'd4, 8'd5, 8'd5, 8'd5, 8'd4, 8'd3};
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/line_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_window
	import blur_pkg::*;
#(
	parameter int LINE_WIDTH = 640
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	input wire logic [PIXEL_W-1:0] pixel_in,
	output logic [PIXEL_W-1:0] window [KERNEL_SIZE][KERNEL_SIZE],
	output logic window_valid
);

	localparam int ADDR_W = $clog2(LINE_WIDTH);
	localparam int NUM_LINES = KERNEL_SIZE - 1;

	logic [ADDR_W-1:0] col;
	logic [PIXEL_W-1:0] line_mem [NUM_LINES][LINE_WIDTH];
	logic [PIXEL_W-1:0] col_in [KERNEL_SIZE];

	// ====================
	// Column counter
	// ====================
	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			window_valid <= 1'b0;
		end else begin
			window_valid <= pixel_valid;
			if (pixel_valid) begin
				if (col == ADDR_W'(LINE_WIDTH - 1))
					col <= '0;
				else
					col <= col + 1'b1;
			end
		end
	end

	// Memory 0 holds the previous line, memory 5 the oldest.
	always_comb begin
		col_in[KERNEL_SIZE-1] = pixel_in; // Current line.
		for (int r = 0; r < KERNEL_SIZE - 1; r++) begin
			col_in[r] = line_mem[NUM_LINES-1-r][col];
		end
	end

	// ====================
	// Line chain and window
	// ====================
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			line_mem[0][col] <= pixel_in;
			for (int i = 1; i < NUM_LINES; i++) begin
				line_mem[i][col] <= line_mem[i-1][col]; // Ripple one line down.
			end

			for (int r = 0; r < KERNEL_SIZE; r++) begin
				for (int c = 0; c < KERNEL_SIZE - 1; c++) begin
					window[r][c] <= window[r][c+1];
				end
				window[r][KERNEL_SIZE-1] <= col_in[r]; // Newest column enters right.
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pixel_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_result
	import blur_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [SUM_W-1:0] sum_r,
	input wire logic [SUM_W-1:0] sum_g,
	input wire logic [SUM_W-1:0] sum_b,
	input wire logic sum_valid,
	input wire logic [PIXEL_W-1:0] side_in,
	output logic [CHAN_W-1:0] out_r,
	output logic [CHAN_W-1:0] out_g,
	output logic [CHAN_W-1:0] out_b,
	output logic out_valid,
	output logic [PIXEL_W-1:0] side_out
);

	logic [PIXEL_W-1:0] side_d1;
	logic [PIXEL_W-1:0] side_d2;

	// Drop the fraction, clamp anything above 255.
	function automatic logic [CHAN_W-1:0] saturate(input logic [SUM_W-1:0] sum);
		logic [SUM_W-COEFF_SHIFT-1:0] scaled;
		scaled = sum[SUM_W-1:COEFF_SHIFT];
		if (|scaled[SUM_W-COEFF_SHIFT-1:CHAN_W])
			return '1;
		return scaled[CHAN_W-1:0];
	endfunction

	// Matches the window and sum stages.
	always_ff @(posedge clk) begin
		side_d1 <= side_in;
		side_d2 <= side_d1;
	end

	always_ff @(posedge clk) begin
		if (sum_valid) begin
			out_r <= saturate(sum_r);
			out_g <= saturate(sum_g);
			out_b <= saturate(sum_b);
			side_out <= side_d2; // Sideband of the same pixel.
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= sum_valid;
	end

endmodule

`default_nettype wire
